// ==== src/fetch_pkg.sv ====
// RV64 fetch front end definitions; no compressed instructions, and pc is always word aligned
package fetch_pkg;

  localparam int xlen = 64;
  localparam int ilen = 32;

  localparam int imem_depth = 64; // Instruction words
  localparam int imem_aw    = 6;
  localparam int reg_aw     = 5;

  typedef logic [xlen-1:0] xword_t;
  typedef logic [ilen-1:0] inst_t;

  // Opcode field is instruction bits 6 to 2, the low two bits are always 2'b11
  localparam logic [4:0] op_jal    = 5'b11011;
  localparam logic [4:0] op_jalr   = 5'b11001;
  localparam logic [4:0] op_branch = 5'b11000;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam xword_t reset_pc = '0; // Also the restart address of every run

  localparam int cnt_w = 8;

  typedef enum logic [1:0] {
    idle  = 2'd0,
    fetch = 2'd1,
    halt  = 2'd2
  } fetch_state_t;

endpackage

// ==== src/sync_ram.sv ====
// Write is synchronous and reads are combinational, with no reset of the contents
`timescale 1ns/1ps

module sync_ram #(
  parameter type elem_t = logic [31:0],
  parameter int  depth  = 64,
  parameter int  aw     = $clog2(depth)
) (
  input  logic          clk,
  input  logic          we,
  input  logic [aw-1:0] waddr,
  input  elem_t         wdata,
  input  logic [aw-1:0] raddr_a,
  output elem_t         rdata_a,
  input  logic [aw-1:0] raddr_b,
  output elem_t         rdata_b
);

  elem_t mem [depth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Both ports see the old word in the cycle of a write to the same address
  assign rdata_a = mem[raddr_a];
  assign rdata_b = mem[raddr_b];

endmodule

// ==== src/minidecode.sv ====
// Purely combinational jump decode; target is not checked for alignment and x0 is not forced to zero
`timescale 1ns/1ps

module minidecode
  import fetch_pkg::*;
(
  input  xword_t            pc,
  input  inst_t             inst,
  output logic [reg_aw-1:0] rs1,
  input  xword_t            rs1_data,
  output logic [reg_aw-1:0] rs2,
  input  xword_t            rs2_data,
  output logic              pc_jmp,
  output xword_t            pc_jmpaddr
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  xword_t     i_imm;
  xword_t     j_imm;
  xword_t     b_imm;
  xword_t     jalr_sum;
  logic       is_jal;
  logic       is_jalr;
  logic       is_branch;
  logic       cond;

  assign opcode = inst[6:2];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign i_imm = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign j_imm = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign b_imm = {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  assign is_jal    = (opcode == op_jal);
  assign is_jalr   = (opcode == op_jalr);
  assign is_branch = (opcode == op_branch);

  assign jalr_sum = rs1_data + i_imm;

  // Only the comparison named by funct3 decides the branch
  always_comb begin
    case (funct3)
      f3_beq:  cond = (rs1_data == rs2_data);
      f3_bne:  cond = (rs1_data != rs2_data);
      f3_blt:  cond = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: cond = (rs1_data < rs2_data);
      f3_bgeu: cond = (rs1_data >= rs2_data);
      default: cond = 1'b0; // Reserved funct3 codes never branch
    endcase
  end

  assign pc_jmp = is_jal | is_jalr | (is_branch & cond);

  always_comb begin
    if (is_jal) begin
      pc_jmpaddr = pc + j_imm;
    end else if (is_jalr) begin
      pc_jmpaddr = {jalr_sum[xlen-1:1], 1'b0}; // Bit 0 is cleared as the ISA requires
    end else if (is_branch && cond) begin
      pc_jmpaddr = pc + b_imm;
    end else begin
      pc_jmpaddr = '0;
    end
  end

endmodule

// ==== src/pc_unit.sv ====
// The pc only moves while fetch_en is high, and load_start takes priority over stepping
`timescale 1ns/1ps

module pc_unit
  import fetch_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   fetch_en,
  input  logic   load_start,
  input  logic   pc_jmp,
  input  xword_t pc_jmpaddr,
  output xword_t pc
);

  xword_t pc_next;

  assign pc_next = pc_jmp ? pc_jmpaddr : pc + xword_t'(4);

  always_ff @(posedge clk) begin
    if (rst || load_start) begin
      pc <= reset_pc;
    end else if (fetch_en) begin
      pc <= pc_next; // One step per fetched word
    end
  end

endmodule

// ==== src/fetch_counter.sv ====
// The limit is captured with load_start, and a limit of 0 runs a single fetch
`timescale 1ns/1ps

module fetch_counter
  import fetch_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             load_start,
  input  logic             fetch_en,
  input  logic [cnt_w-1:0] fetch_limit,
  output logic             limit_hit
);

  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] limit_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      count   <= '0;
      limit_q <= cnt_w'(1);
    end else if (load_start) begin
      count   <= '0;
      limit_q <= (fetch_limit == '0) ? cnt_w'(1) : fetch_limit;
    end else if (fetch_en) begin
      count <= count + cnt_w'(1);
    end
  end

  // High during the cycle of the last fetch, so the FSM halts on its closing edge
  assign limit_hit = fetch_en && (count + cnt_w'(1) == limit_q);

endmodule

// ==== src/fetch_fsm.sv ====
// A start while fetching is dropped; the run ends only through limit_hit
`timescale 1ns/1ps

module fetch_fsm
  import fetch_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic limit_hit,
  output logic fetch_en,
  output logic load_start,
  output logic done
);

  fetch_state_t state;
  fetch_state_t state_next;

  assign load_start = start && (state != fetch);

  always_comb begin
    state_next = state;
    case (state)
      idle:    if (start) state_next = fetch;
      fetch:   if (limit_hit) state_next = halt;
      halt:    if (start) state_next = fetch; // Restart from reset_pc
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  assign fetch_en = (state == fetch);
  assign done     = (state == halt);

endmodule

// ==== src/fetch_frontend.sv ====
// Memories must not be written during a run; fetch outputs are combinational from pc
`timescale 1ns/1ps

module fetch_frontend
  import fetch_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               imem_we,
  input  logic [imem_aw-1:0] imem_waddr,
  input  inst_t              imem_wdata,
  input  logic               reg_we,
  input  logic [reg_aw-1:0]  reg_waddr,
  input  xword_t             reg_wdata,
  input  logic               start,
  input  logic [cnt_w-1:0]   fetch_limit,
  output logic               fetch_valid,
  output xword_t             fetch_pc,
  output inst_t              fetch_inst,
  output logic               fetch_taken,
  output logic               done
);

  xword_t             pc;
  inst_t              inst;
  logic [reg_aw-1:0]  rs1;
  logic [reg_aw-1:0]  rs2;
  xword_t             rs1_data;
  xword_t             rs2_data;
  logic               pc_jmp;
  xword_t             pc_jmpaddr;
  logic               fetch_en;
  logic               load_start;
  logic               limit_hit;
  logic [imem_aw-1:0] pc_word;

  assign pc_word = pc[imem_aw+1:2]; // Word index into imem

  sync_ram #(.elem_t(inst_t), .depth(imem_depth)) imem_i (
    .clk(clk), .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata),
    .raddr_a(pc_word), .rdata_a(inst),
    .raddr_b(pc_word), .rdata_b()
  );

  sync_ram #(.elem_t(xword_t), .depth(1 << reg_aw)) regfile_i (
    .clk(clk), .we(reg_we), .waddr(reg_waddr), .wdata(reg_wdata),
    .raddr_a(rs1), .rdata_a(rs1_data),
    .raddr_b(rs2), .rdata_b(rs2_data)
  );

  minidecode minidecode_i (
    .pc(pc), .inst(inst),
    .rs1(rs1), .rs1_data(rs1_data), .rs2(rs2), .rs2_data(rs2_data),
    .pc_jmp(pc_jmp), .pc_jmpaddr(pc_jmpaddr)
  );

  pc_unit pc_unit_i (
    .clk(clk), .rst(rst), .fetch_en(fetch_en), .load_start(load_start),
    .pc_jmp(pc_jmp), .pc_jmpaddr(pc_jmpaddr), .pc(pc)
  );

  fetch_counter fetch_counter_i (
    .clk(clk), .rst(rst), .load_start(load_start), .fetch_en(fetch_en),
    .fetch_limit(fetch_limit), .limit_hit(limit_hit)
  );

  fetch_fsm fetch_fsm_i (
    .clk(clk), .rst(rst), .start(start), .limit_hit(limit_hit),
    .fetch_en(fetch_en), .load_start(load_start), .done(done)
  );

  assign fetch_valid = fetch_en;
  assign fetch_pc    = pc;
  assign fetch_inst  = inst;
  assign fetch_taken = pc_jmp;

endmodule

// ==== verification/fetch_checker.sv ====
// Samples on the falling edge, so memory writes must not overlap a run, as in the DUT
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               imem_we,
  input  logic [imem_aw-1:0] imem_waddr,
  input  inst_t              imem_wdata,
  input  logic               reg_we,
  input  logic [reg_aw-1:0]  reg_waddr,
  input  xword_t             reg_wdata,
  input  logic               start,
  input  logic [cnt_w-1:0]   fetch_limit,
  input  logic               fetch_valid,
  input  xword_t             fetch_pc,
  input  inst_t              fetch_inst,
  input  logic               fetch_taken,
  input  logic               done,
  input  logic               check_req,
  input  xword_t             exp_pc,
  input  int                 exp_taken,
  output int                 error_count
);

  inst_t  imem [imem_depth];
  xword_t regs [1 << reg_aw];
  xword_t model_pc;
  logic   running;
  logic   run_seen;
  int     fetches;
  int     valid_cnt;
  int     taken_cnt;
  int     lim;

  // Returns the taken flag above the next pc, decoded from the full 7-bit opcode
  function automatic logic [64:0] predict(input xword_t pc, input inst_t w);
    xword_t a;
    xword_t b;
    logic   hit;
    a = regs[w[19:15]];
    b = regs[w[24:20]];
    if (w[6:0] == 7'h6f) begin
      return {1'b1, pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0}};
    end
    if (w[6:0] == 7'h67) begin
      return {1'b1, (a + {{52{w[31]}}, w[31:20]}) & ~64'd1};
    end
    if (w[6:0] != 7'h63) return {1'b0, pc + 64'd4};
    case (w[14:12])
      3'd0:    hit = (a == b);
      3'd1:    hit = (a != b);
      3'd4:    hit = ($signed(a) < $signed(b));
      3'd5:    hit = ($signed(a) >= $signed(b));
      3'd6:    hit = (a < b);
      3'd7:    hit = (a >= b);
      default: hit = 1'b0;
    endcase
    if (!hit) return {1'b0, pc + 64'd4};
    return {1'b1, pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0}};
  endfunction

  task automatic fail_hex(input string name, input xword_t got, input xword_t want);
    $display("ERROR %s: got %h expected %h", name, got, want);
    error_count++;
  endtask

  initial error_count = 0;

  always @(negedge clk) begin
    logic [64:0] pred;
    inst_t       w;
    if (rst) begin
      running  = 1'b0;
      run_seen = 1'b0;
    end else begin
      if (imem_we) imem[imem_waddr] = imem_wdata;
      if (reg_we) regs[reg_waddr] = reg_wdata;
      if (done !== (run_seen && !running)) fail_hex("done", 64'(done), 64'(run_seen && !running));
      if (fetch_valid !== running) fail_hex("fetch_valid", 64'(fetch_valid), 64'(running));
      if (fetch_valid) valid_cnt++; // Every DUT fetch counts, expected or not
      if (running && fetch_valid) begin
        w = imem[model_pc[7:2]];
        pred = predict(model_pc, w);
        if (fetch_pc !== model_pc) fail_hex("fetch_pc", fetch_pc, model_pc);
        if (fetch_inst !== w) fail_hex("fetch_inst", 64'(fetch_inst), 64'(w));
        if (fetch_taken !== pred[64]) fail_hex("fetch_taken", 64'(fetch_taken), 64'(pred[64]));
        if (fetch_taken) taken_cnt++;
        model_pc = pred[63:0];
        fetches++;
        if (fetches == lim) running = 1'b0;
      end else if (start && !running) begin // Starts during a run are ignored
        running   = 1'b1;
        run_seen  = 1'b1;
        model_pc  = reset_pc;
        fetches   = 0;
        valid_cnt = 0;
        taken_cnt = 0;
        lim       = (fetch_limit == '0) ? 1 : int'(fetch_limit);
      end
      if (check_req) begin
        if (fetch_pc !== exp_pc) fail_hex("final pc", fetch_pc, exp_pc);
        if (taken_cnt != exp_taken) fail_hex("taken count", 64'(taken_cnt), 64'(exp_taken));
        if (valid_cnt != lim) fail_hex("fetch_valid count", 64'(valid_cnt), 64'(lim));
      end
    end
  end

endmodule

// ==== verification/fetch_frontend_sva.sv ====
// Bound into fetch_frontend; it reads the FSM state through the fetch_fsm_i instance
`timescale 1ns/1ps

module fetch_frontend_sva import fetch_pkg::*; (
  input logic         clk,
  input logic         rst,
  input fetch_state_t state,
  input logic         start,
  input logic         fetch_valid,
  input logic         done,
  input xword_t       pc
);

  // Leaving idle takes a start, so a quiet idle cycle is never followed by a fetch
  no_fetch_from_idle: assert property (@(posedge clk) disable iff (rst)
    (state == idle && !start) |=> !fetch_valid)
    else $error("fetch_valid rose out of idle without a start");

  done_after_fetch: assert property (@(posedge clk) disable iff (rst)
    $rose(done) |-> $past(fetch_valid))
    else $error("done rose without a closing fetch cycle");

  done_holds: assert property (@(posedge clk) disable iff (rst)
    (done && !start) |=> done)
    else $error("done dropped without a start");

  // Targets are never misaligned in this front end
  pc_aligned: assert property (@(posedge clk) disable iff (rst)
    (state == fetch) |-> (pc[1:0] == 2'b00))
    else $error("pc is not word aligned during a fetch");

endmodule

bind fetch_frontend fetch_frontend_sva sva_i (
  .clk(clk), .rst(rst), .state(fetch_fsm_i.state), .start(start),
  .fetch_valid(fetch_valid), .done(done), .pc(pc)
);

// ==== verification/fetch_frontend_tb.sv ====
// Runs from the project root, where it reads verification/fetch_tests.txt
`timescale 1ns/1ps

module fetch_frontend_tb import fetch_pkg::*; ();

  logic               clk = 1'b0;
  logic               rst;
  logic               imem_we;
  logic [imem_aw-1:0] imem_waddr;
  inst_t              imem_wdata;
  logic               reg_we;
  logic [reg_aw-1:0]  reg_waddr;
  xword_t             reg_wdata;
  logic               start;
  logic [cnt_w-1:0]   fetch_limit;
  logic               fetch_valid;
  xword_t             fetch_pc;
  inst_t              fetch_inst;
  logic               fetch_taken;
  logic               done;
  logic               check_req;
  xword_t             exp_pc;
  int                 exp_taken;
  int                 error_count;
  int                 tb_errors = 0;
  int                 watch_cycles = 0;
  int                 seed = 32'hccc7_5cba;

  always #50 clk = ~clk;

  fetch_frontend dut_i (.*);

  fetch_checker checker_i (.*);

  task automatic read_line(input int fd, output string kind, output xword_t a, b, c, d);
    string rest;
    int    code;
    a = '0;
    b = '0;
    c = '0;
    d = '0;
    code = $fscanf(fd, "%s", kind);
    if (code != 1) kind = "";
    else if (kind.getc(0) == "#") code = $fgets(rest, fd);
    else if (kind == "S") code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
    else code = $fscanf(fd, "%h %h", a, b);
  endtask

  // Each write occupies one cycle, the strobe drops 1 ns after its edge
  task automatic write_imem(input logic [imem_aw-1:0] addr, input inst_t data);
    imem_we    = 1'b1;
    imem_waddr = addr;
    imem_wdata = data;
    @(posedge clk);
    #1 imem_we = 1'b0;
  endtask

  task automatic write_reg(input logic [reg_aw-1:0] idx, input xword_t val);
    reg_we    = 1'b1;
    reg_waddr = idx;
    reg_wdata = val;
    @(posedge clk);
    #1 reg_we = 1'b0;
  endtask

  task automatic run_test(input logic [cnt_w-1:0] limit, input int restart, input xword_t pc_w,
                          input int taken_w);
    fetch_limit = limit;
    exp_pc      = pc_w;
    exp_taken   = taken_w;
    start       = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    if (restart != 0) begin
      repeat (restart) @(posedge clk);
      #1 start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
    end
    while (!done) begin
      @(posedge clk);
      #1;
    end
    repeat (3) @(posedge clk); // done must hold in halt
    #1 check_req = 1'b1;
    @(posedge clk);
    #1 check_req = 1'b0;
  endtask

  initial begin
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge clk);
    $display("Timeout after %0d cycles without finishing the tests", watch_cycles);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int     fd;
    int     total;
    string  kind;
    xword_t a, b, c, d;
    rst         = 1'b1;
    imem_we     = 1'b0;
    imem_waddr  = '0;
    imem_wdata  = '0;
    reg_we      = 1'b0;
    reg_waddr   = '0;
    reg_wdata   = '0;
    start       = 1'b0;
    fetch_limit = '0;
    check_req   = 1'b0;
    exp_pc      = '0;
    exp_taken   = 0;
    total = 12; // Reset, random register writes and the closing cycles
    fd = $fopen("verification/fetch_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test file verification/fetch_tests.txt");
      tb_errors++;
    end else forever begin
      read_line(fd, kind, a, b, c, d);
      if (kind == "") break;
      if (kind == "I" || kind == "R") total += 1;
      if (kind == "S") total += ((a == '0) ? 1 : int'(a)) + 20;
    end
    watch_cycles = total;
    if (fd != 0) begin
      $fclose(fd);
      fd = $fopen("verification/fetch_tests.txt", "r");
    end
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    for (int i = 20; i < 24; i++) write_reg(i[reg_aw-1:0], {$random(seed), $random(seed)});
    if (fd != 0) forever begin
      read_line(fd, kind, a, b, c, d);
      if (kind == "") break;
      if (kind == "I") write_imem(a[imem_aw-1:0], b[ilen-1:0]);
      else if (kind == "R") write_reg(a[reg_aw-1:0], b);
      else if (kind == "S") run_test(a[cnt_w-1:0], int'(d), b, int'(c));
      else if (kind.getc(0) != "#") begin
        $display("Unknown line kind %s in the test file", kind);
        tb_errors++;
      end
    end
    repeat (2) @(posedge clk);
    $display("Closing: %0d checker errors, %0d testbench errors", error_count, tb_errors);
    if (error_count == 0 && tb_errors == 0) $display("Done: no errors");
    else $display("Done: errors found");
    $finish;
  end

endmodule

// ==== verification/fetch_tests.txt ====
# I word_addr inst | R reg value | S limit final_pc taken_count restart_after_cycles
# All values hex; x20 to x23 hold random values and are only compared with themselves
R 0 0
R 1 51
R 2 5
R 3 ffffffffffffffff
R 4 5
I 0 00000013
I 1 00000013
I 2 0080006f
I 4 00410463
I 6 00411463
I 7 0021c463
I 9 0021e463
I a 00315463
I c 00317463
I d 00008067
I 14 fe9ff06f
I e 014a0463
I 10 015a9463
I 11 0000006f
S 2 8 0 0
S 0 4 0 0
S 3 10 1 0
S 9 34 4 0
S e 44 8 0
S 10 44 a 5

// ==== sim.f ====
src/fetch_pkg.sv
src/sync_ram.sv
src/minidecode.sv
src/pc_unit.sv
src/fetch_counter.sv
src/fetch_fsm.sv
src/fetch_frontend.sv
verification/fetch_checker.sv
verification/fetch_frontend_sva.sv
verification/fetch_frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the fetch front end simulation with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module fetch_frontend_tb \
  -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/fetch_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
